//--- pcie_settings.svh
`ifndef PCIE_SETTINGS_SVH
`define PCIE_SETTINGS_SVH

// Width of the CQ and CC stream data buses
`define PCIE_DATA_WIDTH 128

// Number of 32-bit registers behind BAR0, register 0 is read-only
`define BAR0_REG_COUNT 16

// Value returned by a read of register 0
`define BAR0_ID_VALUE 32'hC0DE_0A17

// Bus, device and function number placed in every completion
`define COMPLETER_ID 16'h0100

`endif

//--- pcie_pkg.sv
`default_nettype none

package pcie_pkg;

    // Request type field of the CQ descriptor, other codes are unsupported
    typedef enum logic [3:0] {
        REQ_MEM_READ  = 4'd0,
        REQ_MEM_WRITE = 4'd1
    } req_type_e;

    typedef enum logic [2:0] {
        CPL_SC = 3'd0,
        CPL_UR = 3'd1
    } cpl_status_e;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_DATA,
        DEC_WAIT
    } decode_state_e;

    // Decoded request handed from the CQ receiver to the register file
    typedef struct packed {
        logic        is_write;
        logic        bad;
        logic [3:0]  reg_index;
        logic [6:0]  addr_low;
        logic [15:0] requester_id;
        logic [7:0]  tag;
        logic [31:0] wdata;
    } bar_req_t;

    // Outcome of one request, needs_cpl is clear for writes
    typedef struct packed {
        logic        needs_cpl;
        cpl_status_e status;
        logic [6:0]  addr_low;
        logic [15:0] requester_id;
        logic [7:0]  tag;
        logic [31:0] rdata;
    } bar_result_t;

    // One CC beat, listed from bit 127 down to bit 0
    typedef struct packed {
        logic [31:0] rdata;
        logic [7:0]  rsvd_hi;
        logic [15:0] completer_id;
        logic [7:0]  tag;
        logic [15:0] requester_id;
        logic [1:0]  rsvd_mid;
        cpl_status_e status;
        logic [10:0] dword_count;
        logic [2:0]  rsvd_bc;
        logic [12:0] byte_count;
        logic [8:0]  rsvd_lo;
        logic [6:0]  lower_addr;
    } cc_beat_t;

endpackage

`default_nettype wire

//--- cq_decode.sv
`default_nettype none

`include "pcie_settings.svh"

module cq_decode
    import pcie_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire [`PCIE_DATA_WIDTH-1:0]   s_axis_cq_tdata,
    input  wire                          s_axis_cq_tlast,
    input  wire                          s_axis_cq_tvalid,
    output logic                         s_axis_cq_tready,
    input  wire                          retire,
    output bar_req_t                     req,
    output logic                         req_valid
);

    decode_state_e state;
    req_type_e     req_type;
    logic [10:0]   dword_count;
    logic          type_ok;
    logic          beat;

    assign beat        = s_axis_cq_tvalid && s_axis_cq_tready;
    assign req_type    = req_type_e'(s_axis_cq_tdata[78:75]);
    assign dword_count = s_axis_cq_tdata[74:64];
    assign type_ok     = (req_type == REQ_MEM_READ) || (req_type == REQ_MEM_WRITE);

    // Stall the CQ stream while a request is being executed and completed
    assign s_axis_cq_tready = (state != DEC_WAIT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= DEC_IDLE;
            req_valid <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            case (state)
                DEC_IDLE: begin
                    if (beat) begin
                        if (s_axis_cq_tlast) begin
                            state     <= DEC_WAIT;
                            req_valid <= 1'b1;
                        end else begin
                            state <= DEC_DATA;
                        end
                    end
                end
                DEC_DATA: begin
                    // Extra data beats of an oversized write are absorbed here
                    if (beat && s_axis_cq_tlast) begin
                        state     <= DEC_WAIT;
                        req_valid <= 1'b1;
                    end
                end
                DEC_WAIT: begin
                    if (retire) begin
                        state <= DEC_IDLE;
                    end
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (beat && state == DEC_IDLE) begin
            req.is_write     <= (req_type == REQ_MEM_WRITE);
            req.bad          <= !type_ok || (dword_count != 11'd1);
            req.reg_index    <= s_axis_cq_tdata[5:2];
            req.addr_low     <= {s_axis_cq_tdata[6:2], 2'b00};
            req.requester_id <= s_axis_cq_tdata[95:80];
            req.tag          <= s_axis_cq_tdata[103:96];
            req.wdata        <= '0;
        end else if (beat && state == DEC_DATA) begin
            req.wdata <= s_axis_cq_tdata[31:0];
        end
    end

endmodule

`default_nettype wire

//--- bar_reg_execute.sv
`default_nettype none

`include "pcie_settings.svh"

module bar_reg_execute
    import pcie_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire bar_req_t req,
    input  wire          req_valid,
    output bar_result_t  res,
    output logic         res_valid,
    output logic [7:0]   led,
    output logic         status_error_uncor
);

    // Register 0 has no storage and reads back the ID constant
    logic [31:0] regs [1:`BAR0_REG_COUNT-1];
    logic [31:0] rd_value;
    logic        wr_en;
    logic        rd_ok;

    assign rd_value = (req.reg_index == 4'd0) ? `BAR0_ID_VALUE : regs[req.reg_index];
    assign wr_en    = req_valid && req.is_write && !req.bad && (req.reg_index != 4'd0);
    assign rd_ok    = !req.is_write && !req.bad;

    assign led = regs[1][7:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `BAR0_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[req.reg_index] <= req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid          <= 1'b0;
            status_error_uncor <= 1'b0;
        end else begin
            res_valid          <= req_valid;
            status_error_uncor <= req_valid && req.bad;
        end
    end

    // Every request that is not a write gets a completion with SC or UR status
    always_ff @(posedge clk) begin
        if (req_valid) begin
            res.needs_cpl    <= !req.is_write;
            res.status       <= req.bad ? CPL_UR : CPL_SC;
            res.addr_low     <= req.addr_low;
            res.requester_id <= req.requester_id;
            res.tag          <= req.tag;
            res.rdata        <= rd_ok ? rd_value : 32'd0;
        end
    end

endmodule

`default_nettype wire

//--- cc_result.sv
`default_nettype none

`include "pcie_settings.svh"

module cc_result
    import pcie_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire bar_result_t             res,
    input  wire                          res_valid,
    output logic [`PCIE_DATA_WIDTH-1:0]  m_axis_cc_tdata,
    output logic                         m_axis_cc_tlast,
    output logic                         m_axis_cc_tvalid,
    input  wire                          m_axis_cc_tready,
    output logic                         retire
);

    cc_beat_t cpl;
    logic     cpl_ok;
    logic     xfer;
    logic     skip_retire;

    assign cpl_ok = (res.status == CPL_SC);
    assign xfer   = m_axis_cc_tvalid && m_axis_cc_tready;

    // Writes have nothing to send and retire the cycle after their result
    assign retire = xfer || skip_retire;

    assign m_axis_cc_tdata = cpl;
    assign m_axis_cc_tlast = 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_axis_cc_tvalid <= 1'b0;
            skip_retire      <= 1'b0;
        end else begin
            skip_retire <= res_valid && !res.needs_cpl;
            if (res_valid && res.needs_cpl) begin
                m_axis_cc_tvalid <= 1'b1;
            end else if (xfer) begin
                m_axis_cc_tvalid <= 1'b0;
            end
        end
    end

    // The beat is loaded once and held unchanged while the sink stalls
    always_ff @(posedge clk) begin
        if (res_valid && res.needs_cpl) begin
            cpl.rdata        <= res.rdata;
            cpl.rsvd_hi      <= '0;
            cpl.completer_id <= `COMPLETER_ID;
            cpl.tag          <= res.tag;
            cpl.requester_id <= res.requester_id;
            cpl.rsvd_mid     <= '0;
            cpl.status       <= res.status;
            cpl.dword_count  <= cpl_ok ? 11'd1 : 11'd0;
            cpl.rsvd_bc      <= '0;
            cpl.byte_count   <= cpl_ok ? 13'd4 : 13'd0;
            cpl.rsvd_lo      <= '0;
            cpl.lower_addr   <= res.addr_low;
        end
    end

endmodule

`default_nettype wire

//--- fpga_core.sv
`default_nettype none

`include "pcie_settings.svh"

module fpga_core
    import pcie_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst_n,

    input  wire [`PCIE_DATA_WIDTH-1:0]   s_axis_cq_tdata,
    input  wire                          s_axis_cq_tlast,
    input  wire                          s_axis_cq_tvalid,
    output logic                         s_axis_cq_tready,

    output logic [`PCIE_DATA_WIDTH-1:0]  m_axis_cc_tdata,
    output logic                         m_axis_cc_tlast,
    output logic                         m_axis_cc_tvalid,
    input  wire                          m_axis_cc_tready,

    output logic [7:0]                   led,
    output logic                         status_error_cor,
    output logic                         status_error_uncor
);

    bar_req_t    req;
    logic        req_valid;
    bar_result_t res;
    logic        res_valid;
    logic        retire;

    // No correctable errors are detected in the completer path
    assign status_error_cor = 1'b0;

    cq_decode cq_decode_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .s_axis_cq_tdata  (s_axis_cq_tdata),
        .s_axis_cq_tlast  (s_axis_cq_tlast),
        .s_axis_cq_tvalid (s_axis_cq_tvalid),
        .s_axis_cq_tready (s_axis_cq_tready),
        .retire           (retire),
        .req              (req),
        .req_valid        (req_valid)
    );

    bar_reg_execute bar_reg_execute_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .req                (req),
        .req_valid          (req_valid),
        .res                (res),
        .res_valid          (res_valid),
        .led                (led),
        .status_error_uncor (status_error_uncor)
    );

    cc_result cc_result_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .res              (res),
        .res_valid        (res_valid),
        .m_axis_cc_tdata  (m_axis_cc_tdata),
        .m_axis_cc_tlast  (m_axis_cc_tlast),
        .m_axis_cc_tvalid (m_axis_cc_tvalid),
        .m_axis_cc_tready (m_axis_cc_tready),
        .retire           (retire)
    );

endmodule

`default_nettype wire

//--- tb_cc_checker.sv
`default_nettype none

module tb_cc_checker (
    input  wire          clk,
    input  wire          rst_n,
    input  wire          cq_tvalid,
    input  wire          cq_tready,
    input  wire          cq_tlast,
    input  wire  [127:0] cc_tdata,
    input  wire          cc_tlast,
    input  wire          cc_tvalid,
    input  wire          cc_tready,
    input  wire  [7:0]   led,
    input  wire          status_error_cor,
    input  wire          status_error_uncor,
    input  wire          exp_push,
    input  wire  [127:0] exp_cpl,
    input  wire          bad_push,
    input  wire  [7:0]   model_led,
    input  wire          finish_req,
    output int           error_total
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [127:0] exp_queue [$];
    logic [127:0] want;
    logic [127:0] prev_cc_tdata;
    logic         prev_cc_tvalid = 1'b0;
    logic         prev_cc_tready = 1'b0;
    logic         prev_cq_tready = 1'b1;
    logic         in_reset = 1'b1;
    logic         finished = 1'b0;
    int           mismatch_count = 0;
    int           missing_count = 0;
    int           extra_count = 0;
    int           uncor_seen = 0;
    int           uncor_expected = 0;
    int           since_last_beat = 100;

    assign error_total = mismatch_count + missing_count + extra_count;

    // All inputs are sampled at the rising edge, before any of them update
    always @(posedge clk) begin
        if (!rst_n) begin
            in_reset = 1'b1;
        end else begin
            if (in_reset) begin
                in_reset = 1'b0;
                if (!cq_tready || cc_tvalid || led != 8'd0 || status_error_uncor) begin
                    mismatch_count++;
                    $display("Mismatch at %0t: after reset cq_tready=%b cc_tvalid=%b led=%h",
                             $time, cq_tready, cc_tvalid, led);
                end
            end
            if (exp_push) begin
                exp_queue.push_back(exp_cpl);
            end
            if (bad_push) begin
                uncor_expected++;
            end
            if (status_error_uncor) begin
                uncor_seen++;
            end
            if (status_error_cor) begin
                mismatch_count++;
                $display("Mismatch at %0t: status_error_cor is high", $time);
            end

            if (cq_tvalid && cq_tready && cq_tlast) begin
                since_last_beat = 0;
            end else begin
                since_last_beat++;
            end
            if (cc_tvalid && !prev_cc_tvalid && since_last_beat != 3) begin
                mismatch_count++;
                $display("Mismatch at %0t: completion valid %0d cycles after last CQ beat",
                         $time, since_last_beat);
            end

            // A stalled completion must hold its valid and its data
            if (prev_cc_tvalid && !prev_cc_tready &&
                    (!cc_tvalid || cc_tdata != prev_cc_tdata)) begin
                mismatch_count++;
                $display("Mismatch at %0t: completion changed while stalled", $time);
            end
            if (cc_tvalid && cq_tready) begin
                mismatch_count++;
                $display("Mismatch at %0t: CQ ready high while a completion waits", $time);
            end

            if (cc_tvalid && cc_tready) begin
                if (exp_queue.size() == 0) begin
                    extra_count++;
                    $display("Error at %0t: a completion arrived that no request asked for",
                             $time);
                end else begin
                    want = exp_queue.pop_front();
                    if (cc_tdata != want || !cc_tlast) begin
                        mismatch_count++;
                        $display("Mismatch at %0t: completion %h tlast %b, expected %h",
                                 $time, cc_tdata, cc_tlast, want);
                    end
                end
            end

            // CQ ready coming back marks the retirement of a request
            if (cq_tready && !prev_cq_tready && led != model_led) begin
                mismatch_count++;
                $display("Mismatch at %0t: led is %h, expected %h", $time, led, model_led);
            end

            if (finish_req && !finished) begin
                finished = 1'b1;
                if (exp_queue.size() != 0) begin
                    missing_count += exp_queue.size();
                    $display("Error: %0d expected completions never arrived", exp_queue.size());
                end
                if (uncor_seen != uncor_expected) begin
                    mismatch_count++;
                    $display("Mismatch at %0t: %0d uncorrectable error pulses, expected %0d",
                             $time, uncor_seen, uncor_expected);
                end
                $display("Errors: %0d mismatches, %0d missing completions, %0d extra completions",
                         mismatch_count, missing_count, extra_count);
            end
        end
        prev_cc_tvalid = cc_tvalid;
        prev_cc_tready = cc_tready;
        prev_cc_tdata  = cc_tdata;
        prev_cq_tready = cq_tready;
    end

endmodule

`default_nettype wire

//--- tb_fpga_core.sv
`default_nettype none

`include "pcie_settings.svh"

module tb_fpga_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int REQ_COUNT   = 400;
    localparam int CYCLE_LIMIT = REQ_COUNT * 24 + 200;

    logic                        clk;
    logic                        rst_n;
    logic [`PCIE_DATA_WIDTH-1:0] s_axis_cq_tdata;
    logic                        s_axis_cq_tlast;
    logic                        s_axis_cq_tvalid;
    logic                        s_axis_cq_tready;
    logic [`PCIE_DATA_WIDTH-1:0] m_axis_cc_tdata;
    logic                        m_axis_cc_tlast;
    logic                        m_axis_cc_tvalid;
    logic                        m_axis_cc_tready;
    logic [7:0]                  led;
    logic                        status_error_cor;
    logic                        status_error_uncor;

    logic                        exp_push;
    logic [`PCIE_DATA_WIDTH-1:0] exp_cpl;
    logic                        bad_push;
    logic [7:0]                  model_led;
    logic                        finish_req;
    logic                        hold_ready;
    logic [31:0]                 model_regs [16];
    logic [15:0]                 lfsr_state;
    int                          cycle_count = 0;
    int                          error_total;

    fpga_core dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .s_axis_cq_tdata    (s_axis_cq_tdata),
        .s_axis_cq_tlast    (s_axis_cq_tlast),
        .s_axis_cq_tvalid   (s_axis_cq_tvalid),
        .s_axis_cq_tready   (s_axis_cq_tready),
        .m_axis_cc_tdata    (m_axis_cc_tdata),
        .m_axis_cc_tlast    (m_axis_cc_tlast),
        .m_axis_cc_tvalid   (m_axis_cc_tvalid),
        .m_axis_cc_tready   (m_axis_cc_tready),
        .led                (led),
        .status_error_cor   (status_error_cor),
        .status_error_uncor (status_error_uncor)
    );

    tb_cc_checker cc_check (
        .clk                (clk),
        .rst_n              (rst_n),
        .cq_tvalid          (s_axis_cq_tvalid),
        .cq_tready          (s_axis_cq_tready),
        .cq_tlast           (s_axis_cq_tlast),
        .cc_tdata           (m_axis_cc_tdata),
        .cc_tlast           (m_axis_cc_tlast),
        .cc_tvalid          (m_axis_cc_tvalid),
        .cc_tready          (m_axis_cc_tready),
        .led                (led),
        .status_error_cor   (status_error_cor),
        .status_error_uncor (status_error_uncor),
        .exp_push           (exp_push),
        .exp_cpl            (exp_cpl),
        .bad_push           (bad_push),
        .model_led          (model_led),
        .finish_req         (finish_req),
        .error_total        (error_total)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d errors so far", cycle_count, error_total);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Galois LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // One clock edge, with a fresh CC ready value and the model strobes cleared
    task automatic clock_tick();
        logic [31:0] r;
        @(posedge clk);
        take_bits(2, r);
        m_axis_cc_tready <= hold_ready || (r[1:0] != 2'b00);
        exp_push         <= 1'b0;
        bad_push         <= 1'b0;
    endtask

    function automatic logic [127:0] expected_completion(input logic [4:0] addr_bits,
            input logic ur, input logic [15:0] rid, input logic [7:0] tag,
            input logic [31:0] data);
        logic [127:0] c;
        c         = '0;
        c[6:0]    = {addr_bits, 2'b00};
        c[28:16]  = ur ? 13'd0 : 13'd4;
        c[42:32]  = ur ? 11'd0 : 11'd1;
        c[45:43]  = ur ? 3'd1 : 3'd0;
        c[63:48]  = rid;
        c[71:64]  = tag;
        c[87:72]  = `COMPLETER_ID;
        c[127:96] = ur ? 32'd0 : data;
        return c;
    endfunction

    task automatic send_request();
        logic [31:0]  r;
        logic [3:0]   req_type;
        logic [10:0]  dw;
        logic [4:0]   addr_bits;
        logic [7:0]   tag;
        logic [15:0]  rid;
        logic [31:0]  wdata;
        logic [31:0]  rdata;
        logic         is_write;
        logic         bad;
        logic [127:0] desc;

        // Mostly reads and writes, about one request in eight is another type
        take_bits(4, r);
        if (r[3:0] < 4'd7) begin
            req_type = 4'd0;
        end else if (r[3:0] < 4'd14) begin
            req_type = 4'd1;
        end else begin
            take_bits(4, r);
            req_type = 4'd2 + (r[3:0] % 4'd14);
        end
        take_bits(3, r);
        if (r[2:0] != 3'd0) begin
            dw = 11'd1;
        end else begin
            take_bits(4, r);
            dw = (r[3:0] == 4'd1) ? 11'd0 : {7'd0, r[3:0]};
        end
        take_bits(5, r);
        addr_bits = r[4:0];
        take_bits(8, r);
        tag = r[7:0];
        take_bits(16, r);
        rid = r[15:0];
        take_bits(32, wdata);

        is_write = (req_type == 4'd1);
        bad      = (req_type > 4'd1) || (dw != 11'd1);

        desc          = '0;
        desc[6:2]     = addr_bits;
        desc[74:64]   = dw;
        desc[78:75]   = req_type;
        desc[95:80]   = rid;
        desc[103:96]  = tag;

        while (!s_axis_cq_tready) begin
            clock_tick();
        end
        s_axis_cq_tdata  <= desc;
        s_axis_cq_tlast  <= !is_write;
        s_axis_cq_tvalid <= 1'b1;
        clock_tick();
        while (!s_axis_cq_tready) begin
            clock_tick();
        end
        if (is_write) begin
            s_axis_cq_tdata <= {96'd0, wdata};
            s_axis_cq_tlast <= 1'b1;
            clock_tick();
            while (!s_axis_cq_tready) begin
                clock_tick();
            end
        end
        s_axis_cq_tvalid <= 1'b0;
        s_axis_cq_tlast  <= 1'b0;

        if (bad) begin
            bad_push <= 1'b1;
        end
        if (is_write) begin
            if (!bad && addr_bits[3:0] != 4'd0) begin
                model_regs[addr_bits[3:0]] = wdata;
            end
            model_led <= model_regs[1][7:0];
        end else begin
            rdata = (addr_bits[3:0] == 4'd0) ? `BAR0_ID_VALUE : model_regs[addr_bits[3:0]];
            exp_cpl  <= expected_completion(addr_bits, bad, rid, tag, rdata);
            exp_push <= 1'b1;
        end
        // Lets the strobes clear and the DUT drop CQ ready before the next request
        clock_tick();
    endtask

    initial begin
        rst_n            = 1'b0;
        s_axis_cq_tdata  = '0;
        s_axis_cq_tlast  = 1'b0;
        s_axis_cq_tvalid = 1'b0;
        m_axis_cc_tready = 1'b0;
        exp_push         = 1'b0;
        exp_cpl          = '0;
        bad_push         = 1'b0;
        model_led        = 8'd0;
        finish_req       = 1'b0;
        hold_ready       = 1'b1;
        lfsr_state       = 16'd68;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = 32'd0;
        end

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // The first requests run without back-pressure
        for (int i = 0; i < REQ_COUNT; i++) begin
            hold_ready = (i < 20);
            send_request();
        end
        while (!s_axis_cq_tready || m_axis_cc_tvalid) begin
            clock_tick();
        end
        repeat (4) clock_tick();
        finish_req <= 1'b1;
        repeat (3) clock_tick();

        if (error_total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
pcie_pkg.sv
cq_decode.sv
bar_reg_execute.sv
cc_result.sv
fpga_core.sv
tb_cc_checker.sv
tb_fpga_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_fpga_core \
    && ./obj_dir/Vtb_fpga_core | tee /dev/stderr | grep -x '>>> PASS' > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

exit 0
